/* list.f */
uart_pkg.sv
rx_frame_if.sv
uart_tx.sv
uart_rx.sv
rx_fifo.sv
uart.sv
tb_uart.sv

/* tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;
   import uart_pkg::*;

   logic        clk;
   logic        rst_n;
   logic [15:0] cmd_in;
   logic        cmd_vld;
   logic        cmd_rdy;
   logic        tx;
   logic        rx;
   logic        read_rdy;
   logic        read_ack;
   logic [7:0]  read_data;
   logic        read_parity_err;
   logic        read_stop_err;

   integer    seed;
   int        value_errors;
   int        other_errors;
   rx_entry_t expected_q [$]; // model of the receive FIFO.

   uart dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .cmd_in          (cmd_in),
      .cmd_vld         (cmd_vld),
      .cmd_rdy         (cmd_rdy),
      .tx              (tx),
      .rx              (rx),
      .read_rdy        (read_rdy),
      .read_ack        (read_ack),
      .read_data       (read_data),
      .read_parity_err (read_parity_err),
      .read_stop_err   (read_stop_err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // compare tasks and run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic check_entry(input string name, input rx_entry_t expected,
                              input rx_entry_t actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic end_run;
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("Timed out while waiting for %s.", what);
      other_errors++;
      end_run();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmit side with serial monitor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic send_command(input logic [15:0] cmd);
      logic [frames_per_cmd*(data_bits+3)-1:0] line;
      logic [7:0] expected;
      logic [7:0] rebuilt;
      int         cycles;
      int         base;
      int         f;
      int         b;
      cycles = 0;
      while (!cmd_rdy && cycles < 1000) begin
         @(negedge clk);
         cycles++;
      end
      if (!cmd_rdy) begin
         give_up("cmd_rdy before a command");
      end
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      cycles = 0;
      while (!cmd_rdy && cycles < 1000) begin
         if (cycles % clks_per_bit == half_bit) begin
            line[cycles / clks_per_bit] = tx; // middle of each bit.
         end
         cmd_in = 16'($random(seed)); // must be ignored while busy.
         @(negedge clk);
         cycles++;
      end
      cmd_vld = 1'b0;
      if (!cmd_rdy) begin
         give_up("cmd_rdy after a command");
      end
      check_count("cmd_rdy low cycles", frames_per_cmd * (data_bits + 3) * clks_per_bit, cycles);
      for (f = 0; f < frames_per_cmd; f++) begin
         base     = f * (data_bits + 3);
         expected = (f == 0) ? cmd[15:8] : cmd[7:0];
         for (b = 0; b < data_bits; b++) begin
            rebuilt[b] = line[base + 1 + b];
         end
         check_bit("tx start bit", 1'b0, line[base]);
         check_byte("tx data", expected, rebuilt);
         check_bit("tx parity bit", ~^expected, line[base + data_bits + 1]);
         check_bit("tx stop bit", 1'b1, line[base + data_bits + 2]);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // receive side with FIFO model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic drive_frame(input logic [7:0] data, input logic flip_parity,
                              input logic low_stop);
      logic [data_bits+2:0] bits;
      rx_entry_t            entry;
      int                   b;
      entry.data       = data;
      entry.parity_err = flip_parity;
      entry.stop_err   = low_stop;
      if (expected_q.size() < fifo_depth) begin
         expected_q.push_back(entry); // a full FIFO drops the entry.
      end
      bits = {~low_stop, (~^data) ^ flip_parity, data, 1'b0};
      for (b = 0; b < data_bits + 3; b++) begin
         rx = bits[b];
         repeat (clks_per_bit) @(negedge clk);
      end
      rx = 1'b1;
   endtask

   task automatic read_and_check;
      rx_entry_t actual;
      int        cycles;
      cycles = 0;
      while (!read_rdy && cycles < 1000) begin
         @(negedge clk);
         cycles++;
      end
      if (!read_rdy) begin
         give_up("read_rdy");
      end
      actual.data       = read_data;
      actual.parity_err = read_parity_err;
      actual.stop_err   = read_stop_err;
      check_entry("read entry", expected_q.pop_front(), actual);
      read_ack = 1'b1;
      @(negedge clk);
      read_ack = 1'b0;
   endtask

   initial begin
      logic [31:0] word;
      int          i;
      seed         = 32'hcbc8_2ad8;
      value_errors = 0;
      other_errors = 0;
      rst_n        = 1'b0;
      cmd_in       = '0;
      cmd_vld      = 1'b0;
      rx           = 1'b1;
      read_ack     = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      check_bit("tx", 1'b1, tx);
      check_bit("cmd_rdy", 1'b1, cmd_rdy);
      check_bit("read_rdy", 1'b0, read_rdy);

      for (i = 0; i < 6; i++) begin
         word = $random(seed);
         send_command(word[15:0]);
      end
      for (i = 0; i < 8; i++) begin
         word = $random(seed);
         drive_frame(word[7:0], 1'b0, 1'b0);
         read_and_check();
      end
      word = $random(seed);
      drive_frame(word[7:0], 1'b1, 1'b0); // inverted parity bit.
      read_and_check();
      drive_frame(word[15:8], 1'b0, 1'b1); // low stop bit.
      read_and_check();

      for (i = 0; i < 6; i++) begin
         word = $random(seed);
         drive_frame(word[7:0], 1'b0, 1'b0);
      end
      // the last vld trails the stop bit by half a bit plus the synchronizer.
      repeat (clks_per_bit) @(negedge clk);
      for (i = 0; i < fifo_depth; i++) begin
         read_and_check();
      end
      check_bit("read_rdy", 1'b0, read_rdy);
      end_run();
   end

endmodule

/* uart.sv */
`timescale 1ns/1ps

module uart (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   output logic        cmd_rdy,
   output logic        tx,
   input  logic        rx,
   output logic        read_rdy,
   input  logic        read_ack,
   output logic [7:0]  read_data,
   output logic        read_parity_err,
   output logic        read_stop_err
);
   import uart_pkg::*;

   rx_entry_t read_entry;

   rx_frame_if rx_frame ();

   uart_tx u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx u_rx (
      .clk   (clk),
      .rst_n (rst_n),
      .rx    (rx),
      .frame (rx_frame)
   );

   rx_fifo u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .frame      (rx_frame),
      .read_ack   (read_ack),
      .read_rdy   (read_rdy),
      .read_entry (read_entry)
   );

   assign read_data       = read_entry.data; // oldest entry in the FIFO.
   assign read_parity_err = read_entry.parity_err;
   assign read_stop_err   = read_entry.stop_err;

endmodule

/* rx_fifo.sv */
`timescale 1ns/1ps

module rx_fifo (
   input  logic               clk,
   input  logic               rst_n,
   rx_frame_if.sink           frame,
   input  logic               read_ack,
   output logic               read_rdy,
   output uart_pkg::rx_entry_t read_entry
);
   import uart_pkg::*;

   rx_entry_t        mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             push;
   logic             pop;

   // a full FIFO simply drops the new entry.
   assign push = frame.vld && (count != (ptr_w + 1)'(fifo_depth));
   assign pop  = read_ack && read_rdy;

   assign read_rdy   = (count != '0);
   assign read_entry = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {frame.data, frame.parity_err, frame.stop_err};
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers and occupancy
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps.
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   rx_frame_if.source frame
);
   import uart_pkg::*;

   logic                 rx_meta;
   logic                 rx_sync;
   logic                 rx_prev;
   rx_state_t            state;
   logic [rx_cnt_w-1:0]  cnt;
   logic [bit_idx_w-1:0] bit_idx;
   logic [data_bits-1:0] shift_q;
   logic                 parity_err_q;
   logic                 stop_err_q;
   logic                 vld_q;
   logic                 fall;
   logic                 mid_bit;
   logic                 frame_end;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // line synchronizer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync; // only used for edge detection.
      end
   end

   assign fall    = rx_prev & ~rx_sync;
   assign mid_bit = (cnt == rx_cnt_w'(clks_per_bit - 1));
   // Ends one cycle early so that a back-to-back start edge is seen in idle.
   assign frame_end = (cnt == rx_cnt_w'(clks_per_bit + half_bit - 2));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // frame FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= rx_idle;
         cnt     <= '0;
         bit_idx <= '0;
         vld_q   <= 1'b0;
      end else begin
         vld_q <= 1'b0;
         case (state)
            rx_idle: begin
               if (fall) begin
                  state <= rx_start;
                  cnt   <= '0;
               end
            end
            rx_start: begin
               if (cnt == rx_cnt_w'(half_bit - 1)) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? rx_idle : rx_data; // high here means a glitch.
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            rx_data: begin
               if (mid_bit) begin
                  cnt <= '0;
                  if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                     state <= rx_parity;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            rx_parity: begin
               if (mid_bit) begin
                  cnt   <= '0;
                  state <= rx_stop;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            rx_stop: begin
               if (frame_end) begin
                  cnt   <= '0;
                  vld_q <= 1'b1;
                  state <= rx_idle;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // data arrives LSB first.
   always_ff @(posedge clk) begin
      if (state == rx_data && mid_bit) begin
         shift_q <= {rx_sync, shift_q[data_bits-1:1]};
      end
      if (state == rx_parity && mid_bit) begin
         parity_err_q <= ~^{rx_sync, shift_q};
      end
      if (state == rx_stop && mid_bit) begin
         stop_err_q <= ~rx_sync;
      end
   end

   assign frame.data       = shift_q;
   assign frame.parity_err = parity_err_q;
   assign frame.stop_err   = stop_err_q;
   assign frame.vld        = vld_q;

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   output logic        cmd_rdy,
   output logic        tx
);
   import uart_pkg::*;

   tx_state_t               state;
   logic [bit_cnt_w-1:0]    bit_cnt;
   logic [bit_idx_w-1:0]    bit_idx;
   logic [frame_idx_w-1:0]  frame_idx;
   logic [15:0]             shift_q;
   logic [frames_per_cmd-1:0] par_q;
   logic                    load;
   logic                    bit_end;

   assign load    = cmd_vld && cmd_rdy;
   assign bit_end = (bit_cnt == bit_cnt_w'(clks_per_bit - 1));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // frame sequencing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= tx_idle;
         tx        <= 1'b1;
         cmd_rdy   <= 1'b1;
         bit_cnt   <= '0;
         bit_idx   <= '0;
         frame_idx <= '0;
      end else if (state == tx_idle) begin
         if (load) begin
            state     <= tx_start;
            tx        <= 1'b0; // start bit of the first frame.
            cmd_rdy   <= 1'b0;
            bit_cnt   <= '0;
            frame_idx <= '0;
         end
      end else if (!bit_end) begin
         bit_cnt <= bit_cnt + 1'b1;
      end else begin
         bit_cnt <= '0;
         case (state)
            tx_start: begin
               state   <= tx_data;
               tx      <= shift_q[0];
               bit_idx <= '0;
            end
            tx_data: begin
               if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                  state <= tx_parity;
                  tx    <= par_q[0];
               end else begin
                  bit_idx <= bit_idx + 1'b1;
                  tx      <= shift_q[0];
               end
            end
            tx_parity: begin
               state <= tx_stop;
               tx    <= 1'b1;
            end
            tx_stop: begin
               if (frame_idx == frame_idx_w'(frames_per_cmd - 1)) begin
                  state   <= tx_idle;
                  cmd_rdy <= 1'b1; // line stays high between commands.
               end else begin
                  state     <= tx_start;
                  tx        <= 1'b0;
                  frame_idx <= frame_idx + 1'b1;
               end
            end
            default: begin
               state <= tx_idle;
               tx    <= 1'b1;
            end
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // payload and parity
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bytes are swapped on load so a plain right shift sends the high byte first.
   always_ff @(posedge clk) begin
      if (load) begin
         shift_q <= {cmd_in[7:0], cmd_in[15:8]};
         par_q   <= {~^cmd_in[7:0], ~^cmd_in[15:8]}; // odd parity per byte.
      end else if (bit_end) begin
         if (state == tx_start) begin
            shift_q <= shift_q >> 1;
         end else if (state == tx_data && bit_idx != bit_idx_w'(data_bits - 1)) begin
            shift_q <= shift_q >> 1;
         end else if (state == tx_parity) begin
            par_q <= par_q >> 1;
         end
      end
   end

endmodule

/* rx_frame_if.sv */
`timescale 1ns/1ps

interface rx_frame_if;
   import uart_pkg::*;

   logic [data_bits-1:0] data;
   logic                 parity_err;
   logic                 stop_err;
   logic                 vld; // one cycle per finished frame.

   modport source (
      output data,
      output parity_err,
      output stop_err,
      output vld
   );

   modport sink (
      input data,
      input parity_err,
      input stop_err,
      input vld
   );

endinterface

/* uart_pkg.sv */
package uart_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // serial timing and frame layout
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int clks_per_bit   = 4;
   localparam int half_bit       = clks_per_bit / 2;
   localparam int data_bits      = 8;
   localparam int frames_per_cmd = 2; // high byte goes out first.
   localparam int fifo_depth     = 4;

   localparam int bit_cnt_w   = $clog2(clks_per_bit);
   localparam int rx_cnt_w    = $clog2(clks_per_bit + half_bit); // covers the stop tail.
   localparam int bit_idx_w   = $clog2(data_bits);
   localparam int frame_idx_w = $clog2(frames_per_cmd);
   localparam int ptr_w       = $clog2(fifo_depth);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // state machines and received entry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_parity, tx_stop} tx_state_t;

   typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_parity, rx_stop} rx_state_t;

   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 parity_err;
      logic                 stop_err;
   } rx_entry_t;

endpackage
